/* sd_dat.f */
hdl/sd_dat_pkg.sv
hdl/data_fifo.sv
hdl/dat_controller.sv
hdl/dat_phy.sv
hdl/sd_dat_top.sv
test/sd_dat_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log

verilator --binary --timing --timescale 1ns/1ps -f sd_dat.f --top-module sd_dat_tb \
  -o sd_dat_sim \
  && ./obj_dir/sd_dat_sim > sim.log 2>&1 \
  || { echo "build or simulation run did not complete"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "simulation reported errors"; exit 1; } \
  || { echo "simulation clean"; exit 0; }

/* test/sd_dat_tb.sv */
`timescale 1ns/1ps

module sd_dat_tb;

  import sd_dat_pkg::*;

  localparam int BLOCK_BYTES = 4;
  localparam int FIFO_DEPTH  = 16;
  localparam int FRAME_BITS  = 8 * BLOCK_BYTES + 2;
  localparam int NUM_BLOCKS  = 6;
  localparam int CYCLE_LIMIT = 40 * NUM_BLOCKS * (8 * BLOCK_BYTES + 20);

  typedef data_byte_t byte_q_t[$];
  typedef logic bit_q_t[$];

  logic       clock;
  logic       reset;
  logic       host_wr;
  data_byte_t host_wdata;
  logic       host_rd;
  logic       new_dat;
  logic       write_read;
  logic       dat_in;
  data_byte_t host_rdata;
  logic       busy;
  logic       write_data;
  logic       read_data;
  logic       dat_out;
  logic       dat_oe;
  logic       frame_error;

  integer  seed;
  int      cycles;
  int      errors;
  int      errors_before;
  int      tests_run;
  int      tests_failed;
  int      oe_cycles;
  bit_q_t  exp_bits;
  byte_q_t fifo_model;
  byte_q_t block;

  sd_dat_top #(
    .BLOCK_BYTES (BLOCK_BYTES),
    .FIFO_DEPTH  (FIFO_DEPTH)
  ) u_sd_dat_top (
    .clock       (clock),
    .reset       (reset),
    .host_wr     (host_wr),
    .host_wdata  (host_wdata),
    .host_rd     (host_rd),
    .new_dat     (new_dat),
    .write_read  (write_read),
    .dat_in      (dat_in),
    .host_rdata  (host_rdata),
    .busy        (busy),
    .write_data  (write_data),
    .read_data   (read_data),
    .dat_out     (dat_out),
    .dat_oe      (dat_oe),
    .frame_error (frame_error)
  );

  initial
  begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model and check helpers
  ////////////////////////////////////////////////////////////////////////////

  // start bit, bytes MSB first, end bit
  function automatic bit_q_t frame_bits(input byte_q_t data);
    bit_q_t bits;
    bits.push_back(1'b0);
    foreach (data[i])
    begin
      for (int b = 7; b >= 0; b--)
      begin
        bits.push_back(data[i][b]);
      end
    end
    bits.push_back(1'b1);
    return bits;
  endfunction

  function automatic byte_q_t random_block();
    byte_q_t data;
    repeat (BLOCK_BYTES)
    begin
      data.push_back(data_byte_t'($random(seed)));
    end
    return data;
  endfunction

  function automatic void report_error(input string what);
    $display("error at %0t: %s", $time, what);
    errors++;
  endfunction

  function automatic void check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("mismatch at %0t: %s expected %0b, got %0b", $time, name, exp, act);
      errors++;
    end
  endfunction

  function automatic void check_int(input string name, input int exp, input int act);
    if (act != exp)
    begin
      $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      errors++;
    end
  endfunction

  function automatic void end_test(input string name);
    tests_run++;
    if (errors != errors_before)
    begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    end
    else
    begin
      $display("test %0d %s: ok", tests_run, name);
    end
    errors_before = errors;
  endfunction

  // the next block leaves the model FIFO and becomes the expected frame
  function automatic void expect_block();
    byte_q_t data;
    repeat (BLOCK_BYTES)
    begin
      data.push_back(fifo_model.pop_front());
    end
    exp_bits  = frame_bits(data);
    oe_cycles = 0;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic host_write(input data_byte_t value);
    @(posedge clock);
    host_wr    <= 1'b1;
    host_wdata <= value;
    fifo_model.push_back(value);
    @(posedge clock);
    host_wr <= 1'b0;
  endtask

  task automatic host_pop_check();
    @(negedge clock);
    if (fifo_model.size() == 0)
    begin
      report_error("host read with nothing expected in the FIFO");
    end
    else
    begin
      check_int("host_rdata", int'(fifo_model.pop_front()), int'(host_rdata));
    end
    @(posedge clock);
    host_rd <= 1'b1;
    @(posedge clock);
    host_rd <= 1'b0;
  endtask

  task automatic start_block(input logic dir);
    @(posedge clock);
    new_dat    <= 1'b1;
    write_read <= dir;
    @(posedge clock);
    new_dat <= 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge clock);
    while (busy)
    begin
      @(negedge clock);
    end
  endtask

  // card side of a read after some idle line time
  task automatic send_frame(input byte_q_t data, input logic end_bit);
    bit_q_t bits;
    bits = frame_bits(data);
    bits[bits.size() - 1] = end_bit;
    repeat (8) @(posedge clock);
    foreach (bits[i])
    begin
      @(posedge clock);
      dat_in <= bits[i];
    end
    @(posedge clock);
    dat_in <= 1'b1;
  endtask

  task automatic read_block(input logic end_bit);
    block = random_block();
    start_block(1'b0);
    @(negedge clock);
    check_bit("read_data", 1'b1, read_data);
    send_frame(block, end_bit);
    // end bit has just been sampled, the transfer is still running
    @(negedge clock);
    check_bit("read_data", 1'b1, read_data);
    wait_idle();
    check_bit("frame_error", !end_bit, frame_error);
    foreach (block[i])
    begin
      fifo_model.push_back(block[i]);
    end
    repeat (BLOCK_BYTES) host_pop_check();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // line monitor and timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clock)
  begin
    if (!reset && dat_oe)
    begin
      oe_cycles++;
      if (!write_data)
      begin
        report_error("dat_oe high outside a write transfer");
      end
      if (exp_bits.size() == 0)
      begin
        report_error("dat_oe high with no frame bit expected");
      end
      else
      begin
        check_bit("dat_out", exp_bits.pop_front(), dat_out);
      end
    end
  end

  always @(posedge clock)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial
  begin
    seed          = 32'h4b46f5f1;
    cycles        = 0;
    errors        = 0;
    errors_before = 0;
    tests_run     = 0;
    tests_failed  = 0;
    oe_cycles     = 0;
    reset         = 1'b1;
    host_wr       = 1'b0;
    host_wdata    = '0;
    host_rd       = 1'b0;
    new_dat       = 1'b0;
    write_read    = 1'b0;
    dat_in        = 1'b1;
    repeat (8) @(posedge clock);
    reset <= 1'b0;

    @(negedge clock);
    check_bit("busy", 1'b0, busy);
    check_bit("write_data", 1'b0, write_data);
    check_bit("read_data", 1'b0, read_data);
    check_bit("dat_oe", 1'b0, dat_oe);
    check_bit("frame_error", 1'b0, frame_error);
    check_bit("dat_out", 1'b1, dat_out);
    end_test("reset state");

    repeat (BLOCK_BYTES) host_write(data_byte_t'($random(seed)));
    expect_block();
    start_block(1'b1);
    @(negedge clock);
    check_bit("write_data", 1'b1, write_data);
    wait_idle();
    check_int("frame bits left", 0, exp_bits.size());
    check_int("dat_oe cycles", FRAME_BITS, oe_cycles);
    check_bit("dat_oe", 1'b0, dat_oe);
    end_test("block write");

    // half a block queued so the controller holds in the FIFO check
    repeat (BLOCK_BYTES / 2) host_write(data_byte_t'($random(seed)));
    start_block(1'b1);
    repeat (FRAME_BITS)
    begin
      @(negedge clock);
      check_bit("dat_oe", 1'b0, dat_oe);
      check_bit("busy", 1'b1, busy);
    end
    repeat (BLOCK_BYTES - BLOCK_BYTES / 2) host_write(data_byte_t'($random(seed)));
    expect_block();
    wait_idle();
    check_int("frame bits left", 0, exp_bits.size());
    check_int("dat_oe cycles", FRAME_BITS, oe_cycles);
    end_test("write waits for data");

    read_block(1'b1);
    end_test("block read");

    read_block(1'b0);
    read_block(1'b1);
    end_test("frame error set and cleared");

    repeat (2 * BLOCK_BYTES) host_write(data_byte_t'($random(seed)));
    expect_block();
    start_block(1'b1);
    @(negedge clock);
    while (!dat_oe)
    begin
      @(negedge clock);
    end
    start_block(1'b1);
    wait_idle();
    repeat (2 * FRAME_BITS)
    begin
      @(negedge clock);
      check_bit("dat_oe", 1'b0, dat_oe);
      check_bit("busy", 1'b0, busy);
    end
    check_int("dat_oe cycles", FRAME_BITS, oe_cycles);
    // second block must still be waiting in the FIFO
    repeat (BLOCK_BYTES) host_pop_check();
    end_test("new_dat while busy");

    $display("tests run %0d, tests with errors %0d, checks failed %0d",
             tests_run, tests_failed, errors);
    if (errors == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* hdl/sd_dat_top.sv */
`timescale 1ns/1ps

module sd_dat_top #(
  parameter int BLOCK_BYTES = 4,
  parameter int FIFO_DEPTH  = 16
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   host_wr,
  input  sd_dat_pkg::data_byte_t host_wdata,
  input  logic                   host_rd,
  input  logic                   new_dat,
  input  logic                   write_read,
  input  logic                   dat_in,
  output sd_dat_pkg::data_byte_t host_rdata,
  output logic                   busy,
  output logic                   write_data,
  output logic                   read_data,
  output logic                   dat_out,
  output logic                   dat_oe,
  output logic                   frame_error
);

  import sd_dat_pkg::*;

  fifo_count_t fifo_count;
  data_byte_t  phy_wdata;
  logic        phy_rd;
  logic        phy_wr;
  logic        transmit;
  logic        receive;
  logic        serial_ready;
  logic        complete;

  // FIFO head feeds both the host and the serializer
  data_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_data_fifo (
    .clock      (clock),
    .reset      (reset),
    .host_wr    (host_wr),
    .host_wdata (host_wdata),
    .host_rd    (host_rd),
    .phy_wr     (phy_wr),
    .phy_wdata  (phy_wdata),
    .phy_rd     (phy_rd),
    .rdata      (host_rdata),
    .count      (fifo_count)
  );

  dat_controller #(
    .BLOCK_BYTES (BLOCK_BYTES),
    .FIFO_DEPTH  (FIFO_DEPTH)
  ) u_dat_controller (
    .clock        (clock),
    .reset        (reset),
    .new_dat      (new_dat),
    .write_read   (write_read),
    .serial_ready (serial_ready),
    .complete     (complete),
    .fifo_count   (fifo_count),
    .busy         (busy),
    .write_data   (write_data),
    .read_data    (read_data),
    .transmit     (transmit),
    .receive      (receive)
  );

  dat_phy #(
    .BLOCK_BYTES (BLOCK_BYTES)
  ) u_dat_phy (
    .clock        (clock),
    .reset        (reset),
    .transmit     (transmit),
    .receive      (receive),
    .dat_in       (dat_in),
    .fifo_rdata   (host_rdata),
    .serial_ready (serial_ready),
    .complete     (complete),
    .dat_out      (dat_out),
    .dat_oe       (dat_oe),
    .fifo_rd      (phy_rd),
    .fifo_wr      (phy_wr),
    .fifo_wdata   (phy_wdata),
    .frame_error  (frame_error)
  );

endmodule

/* hdl/dat_phy.sv */
`timescale 1ns/1ps

module dat_phy #(
  parameter int BLOCK_BYTES = 4
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   transmit,
  input  logic                   receive,
  input  logic                   dat_in,
  input  sd_dat_pkg::data_byte_t fifo_rdata,
  output logic                   serial_ready,
  output logic                   complete,
  output logic                   dat_out,
  output logic                   dat_oe,
  output logic                   fifo_rd,
  output logic                   fifo_wr,
  output sd_dat_pkg::data_byte_t fifo_wdata,
  output logic                   frame_error
);

  import sd_dat_pkg::*;

  localparam int                BYTE_W     = $clog2(BLOCK_BYTES + 1);
  localparam logic [BYTE_W-1:0] BYTES_LAST = BYTE_W'(BLOCK_BYTES - 1);
  localparam logic [BYTE_W-1:0] BYTES_DONE = BYTE_W'(BLOCK_BYTES);

  typedef enum logic [2:0] {
    mode_idle,
    mode_tx,
    mode_tx_stop,
    mode_rx_hunt,
    mode_rx_data
  } phy_mode_t;

  phy_mode_t         mode;
  logic              transmit_q;
  logic              receive_q;
  logic [2:0]        bit_cnt;
  logic [BYTE_W-1:0] byte_cnt;
  data_byte_t        shift;

  assign serial_ready = (mode == mode_idle);
  // a received byte sits in the shift register for the cycle of its push
  assign fifo_wdata   = shift;

  ////////////////////////////////////////////////////////////////////////////
  // framing and counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      mode        <= mode_idle;
      transmit_q  <= 1'b0;
      receive_q   <= 1'b0;
      bit_cnt     <= '0;
      byte_cnt    <= '0;
      complete    <= 1'b0;
      dat_out     <= 1'b1;
      dat_oe      <= 1'b0;
      fifo_rd     <= 1'b0;
      fifo_wr     <= 1'b0;
      frame_error <= 1'b0;
    end
    else
    begin
      transmit_q <= transmit;
      receive_q  <= receive;
      complete   <= 1'b0;
      fifo_rd    <= 1'b0;
      fifo_wr    <= 1'b0;
      case (mode)
        mode_idle:
        begin
          bit_cnt  <= '0;
          byte_cnt <= '0;
          if (transmit && !transmit_q)
          begin
            // start bit goes out now, first byte is already in the shifter
            mode        <= mode_tx;
            dat_out     <= 1'b0;
            dat_oe      <= 1'b1;
            fifo_rd     <= 1'b1;
            frame_error <= 1'b0;
          end
          else if (receive && !receive_q)
          begin
            mode        <= mode_rx_hunt;
            frame_error <= 1'b0;
          end
        end
        mode_tx:
          if (byte_cnt == BYTES_DONE)
          begin
            dat_out <= 1'b1;
            mode    <= mode_tx_stop;
          end
          else
          begin
            dat_out <= shift[7];
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
            begin
              byte_cnt <= byte_cnt + BYTE_W'(1);
              // first byte was popped at the start bit
              fifo_rd  <= (byte_cnt != BYTES_LAST);
            end
          end
        mode_tx_stop:
        begin
          dat_oe   <= 1'b0;
          complete <= 1'b1;
          mode     <= mode_idle;
        end
        mode_rx_hunt:
          if (!dat_in)
          begin
            mode <= mode_rx_data;
          end
        mode_rx_data:
          if (byte_cnt == BYTES_DONE)
          begin
            // end bit must be 1
            frame_error <= frame_error || !dat_in;
            complete    <= 1'b1;
            mode        <= mode_idle;
          end
          else
          begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
            begin
              byte_cnt <= byte_cnt + BYTE_W'(1);
              fifo_wr  <= 1'b1;
            end
          end
        default:
          mode <= mode_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // shift register, MSB first both ways
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    case (mode)
      mode_idle:
        shift <= fifo_rdata;
      mode_tx:
        shift <= (bit_cnt == 3'd7) ? fifo_rdata : {shift[6:0], 1'b0};
      mode_rx_data:
        if (byte_cnt != BYTES_DONE)
        begin
          shift <= {shift[6:0], dat_in};
        end
      default:
        shift <= shift;
    endcase
  end

endmodule

/* hdl/dat_controller.sv */
`timescale 1ns/1ps

module dat_controller #(
  parameter int BLOCK_BYTES = 4,
  parameter int FIFO_DEPTH  = 16
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    new_dat,
  input  logic                    write_read,
  input  logic                    serial_ready,
  input  logic                    complete,
  input  sd_dat_pkg::fifo_count_t fifo_count,
  output logic                    busy,
  output logic                    write_data,
  output logic                    read_data,
  output logic                    transmit,
  output logic                    receive
);

  import sd_dat_pkg::*;

  localparam fifo_count_t BLOCK_COUNT = fifo_count_t'(BLOCK_BYTES);
  localparam fifo_count_t DEPTH_COUNT = fifo_count_t'(FIFO_DEPTH);

  dat_state_t  state;
  dat_state_t  next_state;
  logic        write_dir;
  logic        next_dir;
  logic        next_busy;
  logic        fifo_okay;
  fifo_count_t fifo_free;

  // a write needs a whole block queued, a read needs room for one
  assign fifo_free = DEPTH_COUNT - fifo_count;
  assign fifo_okay = write_dir ? (fifo_count >= BLOCK_COUNT) : (fifo_free >= BLOCK_COUNT);

  // direction seen by the outputs in the coming cycle
  assign next_dir  = (state == st_idle && new_dat) ? write_read : write_dir;
  assign next_busy = (next_state != st_idle);

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    next_state = state;
    case (state)
      st_reset:
        next_state = st_idle;
      st_idle:
        if (new_dat)
        begin
          next_state = write_read ? st_write_cmd : st_read_cmd;
        end
      st_write_cmd:
        if (serial_ready)
        begin
          next_state = st_check_fifo;
        end
      st_read_cmd:
        if (serial_ready)
        begin
          next_state = st_check_fifo;
        end
      st_check_fifo:
        if (fifo_okay)
        begin
          next_state = st_transfer;
        end
      st_transfer:
        if (complete)
        begin
          next_state = st_idle;
        end
      default:
        next_state = st_idle;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and registered outputs
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state      <= st_reset;
      write_dir  <= 1'b0;
      busy       <= 1'b0;
      write_data <= 1'b0;
      read_data  <= 1'b0;
      transmit   <= 1'b0;
      receive    <= 1'b0;
    end
    else
    begin
      state      <= next_state;
      write_dir  <= next_dir;
      busy       <= next_busy;
      write_data <= next_busy && next_dir;
      read_data  <= next_busy && !next_dir;
      // serial stage only runs once the FIFO check has passed
      transmit   <= (next_state == st_transfer) && next_dir;
      receive    <= (next_state == st_transfer) && !next_dir;
    end
  end

endmodule

/* hdl/data_fifo.sv */
`timescale 1ns/1ps

module data_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    host_wr,
  input  sd_dat_pkg::data_byte_t  host_wdata,
  input  logic                    host_rd,
  input  logic                    phy_wr,
  input  sd_dat_pkg::data_byte_t  phy_wdata,
  input  logic                    phy_rd,
  output sd_dat_pkg::data_byte_t  rdata,
  output sd_dat_pkg::fifo_count_t count
);

  import sd_dat_pkg::*;

  localparam int               PTR_W      = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [PTR_W-1:0] PTR_LAST   = PTR_W'(FIFO_DEPTH - 1);
  localparam fifo_count_t      COUNT_FULL = fifo_count_t'(FIFO_DEPTH);

  data_byte_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  data_byte_t       wdata;
  logic             push;
  logic             pop;

  // host and serial stage never write in the same block, host wins anyway
  assign wdata = host_wr ? host_wdata : phy_wdata;
  assign push  = (host_wr || phy_wr) && (count != COUNT_FULL);
  assign pop   = (host_rd || phy_rd) && (count != '0);
  assign rdata = mem[rd_ptr];

  always_ff @(posedge clock)
  begin
    if (push)
    begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop)
      begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + PTR_W'(1);
      end
      if (push && !pop)
      begin
        count <= count + fifo_count_t'(1);
      end
      else if (pop && !push)
      begin
        count <= count - fifo_count_t'(1);
      end
    end
  end

endmodule

/* hdl/sd_dat_pkg.sv */
package sd_dat_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data path types
  ////////////////////////////////////////////////////////////////////////////

  // one byte on the host and FIFO side
  typedef logic [7:0] data_byte_t;

  // FIFO occupancy, wide enough for a 64 entry FIFO
  typedef logic [6:0] fifo_count_t;

  ////////////////////////////////////////////////////////////////////////////
  // controller FSM
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    st_reset,
    st_idle,
    st_write_cmd,
    st_read_cmd,
    st_check_fifo,
    st_transfer
  } dat_state_t;

endpackage
